/* common/draw_pkg.sv */
// polyline renderer shared definitions
`default_nettype none

package draw_pkg;

  // geometry
  localparam int coord_w     = 15;  // bit 15 of each point half is a flag
  localparam int point_depth = 256;
  localparam int point_aw    = 8;

  // host register map, byte offsets
  localparam logic [11:0] reg_ctrl   = 12'h000;  // bit 0 start
  localparam logic [11:0] reg_color  = 12'h004;  // 15:0 rgb565
  localparam logic [11:0] reg_status = 12'h008;  // bit 0 busy, 15:8 runs
  localparam logic [11:0] point_base = 12'h400;  // point ram window

  // point word layout
  //   14:0  x
  //   15    discontinue, pen up before this point
  //   30:16 y
  //   31    last point of the list

  typedef logic [coord_w-1:0] coord_t;

  typedef struct packed {
    coord_t      x0;
    coord_t      y0;
    coord_t      x1;
    coord_t      y1;
    logic [15:0] color;
  } line_req_t;

  typedef struct packed {
    coord_t           x;      // min corner
    coord_t           y;
    logic [coord_w:0] len;    // pixel count, never zero
    logic             vertical;
    logic [15:0]      color;
  } hvline_t;

  // st7789 commands used per run
  typedef enum logic [7:0] {
    op_caset = 8'h2A,
    op_raset = 8'h2B,
    op_ramwr = 8'h2C
  } lcd_op_e;

  typedef enum logic [2:0] {
    walk_idle, walk_fetch, walk_wait, walk_decode, walk_offer
  } walk_state_e;

  typedef enum logic [1:0] {bres_idle, bres_step, bres_emit} bres_state_e;

  typedef enum logic [1:0] {lcd_idle, lcd_send, lcd_gap} lcd_state_e;

endpackage

`default_nettype wire

/* hdl/draw_regs.sv */
// host registers and point memory
`default_nettype none

module draw_regs (
  input  logic        clk,
  input  logic        reset,
  // wishbone classic slave
  input  logic        cyc,
  input  logic        stb,
  input  logic        we,
  input  logic [9:0]  adr,     // word address
  input  logic [31:0] dat_w,
  output logic [31:0] dat_r,
  output logic        ack,
  // to the rendering chain
  output logic        start,
  output logic [15:0] color,
  input  logic [7:0]  rd_addr,
  output logic [31:0] rd_data,
  input  logic        walk_busy,
  input  logic        bres_busy,
  input  logic        lcd_busy,
  input  logic        run_fire    // run transfer strobe
);
  import draw_pkg::*;

  logic [31:0] point_mem [point_depth];
  logic        busy;
  logic        req;
  logic        sel_ctrl, sel_color, sel_status, sel_point;
  logic [7:0]  run_count;

  assign busy = walk_busy | bres_busy | lcd_busy;
  assign req  = cyc & stb & ~ack;  // new strobe, not yet acked

  // word address decode
  assign sel_ctrl   = (adr == reg_ctrl[11:2]);
  assign sel_color  = (adr == reg_color[11:2]);
  assign sel_status = (adr == reg_status[11:2]);
  assign sel_point  = (adr >= point_base[11:2]);

  always_ff @(posedge clk) begin
    if (reset) begin
      ack       <= 1'b0;
      start     <= 1'b0;
      color     <= '0;
      run_count <= '0;
    end else begin
      ack   <= req;  // single cycle, one after the strobe
      start <= req & we & sel_ctrl & dat_w[0] & ~busy;  // ignored while busy
      if (req && we && sel_color)
        color <= dat_w[15:0];
      if (start)
        run_count <= '0;
      else if (run_fire)
        run_count <= run_count + 8'd1;
    end
  end

  // host port of the point ram, read data lines up with ack
  always_ff @(posedge clk) begin
    if (req && we && sel_point)
      point_mem[adr[point_aw-1:0]] <= dat_w;
    if (sel_point)
      dat_r <= point_mem[adr[point_aw-1:0]];
    else if (sel_color)
      dat_r <= {16'h0000, color};
    else if (sel_status)
      dat_r <= {16'h0000, run_count, 7'b0000000, busy};
    else
      dat_r <= '0;  // ctrl reads zero
  end

  // walker port, one cycle latency
  always_ff @(posedge clk) begin
    rd_data <= point_mem[rd_addr];
  end

  a_ack_single : assert property (@(posedge clk) disable iff (reset) ack |=> !ack);

endmodule

`default_nettype wire

/* hdl/polyline_walker.sv */
// point list walker
`default_nettype none

module polyline_walker (
  input  logic                clk,
  input  logic                reset,
  input  logic                start,
  input  logic [15:0]         color,
  output logic [7:0]          rd_addr,
  input  logic [31:0]         rd_data,
  output draw_pkg::line_req_t line_o,
  output logic                line_valid,
  input  logic                line_ready,
  output logic                walk_busy
);
  import draw_pkg::*;

  walk_state_e state;
  logic [7:0]  addr_q;
  logic        have_pen;   // a pen position exists
  coord_t      pen_x, pen_y;
  coord_t      pt_x, pt_y; // point under decode
  logic        pt_disc;
  logic        pt_last;
  logic [15:0] color_q;    // sampled at start

  assign rd_addr   = addr_q;
  assign walk_busy = (state != walk_idle);

  // control
  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= walk_idle;
      addr_q     <= '0;
      have_pen   <= 1'b0;
      line_valid <= 1'b0;
    end else begin
      case (state)
        walk_idle: if (start) begin
          addr_q   <= '0;
          have_pen <= 1'b0;
          state    <= walk_fetch;
        end
        walk_fetch: state <= walk_wait;  // ram sees address 0
        walk_wait: begin
          addr_q <= addr_q + 8'd1;  // next word reads during decode
          state  <= walk_decode;
        end
        walk_decode: begin
          have_pen <= 1'b1;
          if (have_pen && !pt_disc) begin
            line_valid <= 1'b1;
            state      <= walk_offer;
          end else if (pt_last) begin
            state <= walk_idle;
          end else begin
            state <= walk_wait;
          end
        end
        walk_offer: if (line_ready) begin
          line_valid <= 1'b0;
          state      <= pt_last ? walk_idle : walk_wait;
        end
        default: state <= walk_idle;
      endcase
    end
  end

  // payload
  always_ff @(posedge clk) begin
    if (state == walk_idle && start)
      color_q <= color;
    if (state == walk_wait) begin
      pt_x    <= rd_data[coord_w-1:0];
      pt_disc <= rd_data[15];
      pt_y    <= rd_data[16+coord_w-1:16];
      pt_last <= rd_data[31] | (addr_q == 8'hFF);  // list end or ram end
    end
    if (state == walk_decode) begin
      pen_x     <= pt_x;  // point always becomes the pen
      pen_y     <= pt_y;
      line_o.x0 <= pen_x;
      line_o.y0 <= pen_y;
      line_o.x1 <= pt_x;
      line_o.y1 <= pt_y;
      line_o.color <= color_q;
    end
  end

  a_line_hold : assert property (@(posedge clk) disable iff (reset)
    line_valid && !line_ready |=> $stable(line_o));

endmodule

`default_nettype wire

/* line/bresenham_runs.sv */
// bresenham line to run converter
`default_nettype none

module bresenham_runs (
  input  logic                clk,
  input  logic                reset,
  input  draw_pkg::line_req_t line_i,
  input  logic                line_valid,
  output logic                line_ready,
  output draw_pkg::hvline_t   run_o,
  output logic                run_valid,
  input  logic                run_ready,
  output logic                bres_busy
);
  import draw_pkg::*;

  bres_state_e state;

  // setup from the incoming segment
  coord_t in_dx, in_dy;

  // stepper
  coord_t                  cur_x, cur_y, end_x, end_y;
  logic                    sx, sy;        // 1 = increasing
  logic                    xmajor;
  logic signed [coord_w+3:0] err, e2, dx_s, dy_s, err_nx;
  logic [15:0]             color_q;
  logic                    xstep, ystep, at_end, close_run;
  logic                    last_run;

  // run under construction
  coord_t           run_x, run_y, nx_x, nx_y;
  logic [coord_w:0] run_len, nx_len;

  assign line_ready = (state == bres_idle);
  assign bres_busy  = (state != bres_idle);

  assign in_dx = (line_i.x1 >= line_i.x0) ? line_i.x1 - line_i.x0 : line_i.x0 - line_i.x1;
  assign in_dy = (line_i.y1 >= line_i.y0) ? line_i.y1 - line_i.y0 : line_i.y0 - line_i.y1;

  assign e2     = err <<< 1;
  assign xstep  = (e2 > -dy_s);
  assign ystep  = (e2 < dx_s);
  assign err_nx = err - (xstep ? dy_s : '0) + (ystep ? dx_s : '0);
  assign at_end = (cur_x == end_x) && (cur_y == end_y);
  assign close_run = at_end || (xmajor ? ystep : xstep);  // minor axis moves

  // current pixel appended to the run, min corner kept
  always_comb begin
    if (run_len == '0) begin
      nx_x   = cur_x;
      nx_y   = cur_y;
      nx_len = 1;
    end else begin
      nx_x   = (cur_x < run_x) ? cur_x : run_x;
      nx_y   = (cur_y < run_y) ? cur_y : run_y;
      nx_len = run_len + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= bres_idle;
      run_valid <= 1'b0;
    end else begin
      case (state)
        bres_idle: if (line_valid) state <= bres_step;
        bres_step: if (close_run) begin
          run_valid <= 1'b1;
          state     <= bres_emit;
        end
        bres_emit: if (run_ready) begin
          run_valid <= 1'b0;
          state     <= last_run ? bres_idle : bres_step;
        end
        default: state <= bres_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    case (state)
      bres_idle: begin
        cur_x   <= line_i.x0;
        cur_y   <= line_i.y0;
        end_x   <= line_i.x1;
        end_y   <= line_i.y1;
        sx      <= (line_i.x1 >= line_i.x0);
        sy      <= (line_i.y1 >= line_i.y0);
        dx_s    <= signed'({4'b0000, in_dx});
        dy_s    <= signed'({4'b0000, in_dy});
        err     <= signed'({4'b0000, in_dx}) - signed'({4'b0000, in_dy});
        xmajor  <= (in_dx >= in_dy);
        color_q <= line_i.color;
        run_len <= '0;
      end
      bres_step: begin
        run_x   <= nx_x;
        run_y   <= nx_y;
        run_len <= nx_len;
        if (close_run) begin
          run_o.x        <= nx_x;
          run_o.y        <= nx_y;
          run_o.len      <= nx_len;
          run_o.vertical <= ~xmajor;
          run_o.color    <= color_q;
          last_run       <= at_end;
        end
        if (!at_end) begin  // advance one pixel
          err <= err_nx;
          if (xstep) cur_x <= sx ? cur_x + 1'b1 : cur_x - 1'b1;
          if (ystep) cur_y <= sy ? cur_y + 1'b1 : cur_y - 1'b1;
        end
      end
      bres_emit: if (run_ready) run_len <= '0;  // fresh run next
      default: ;
    endcase
  end

  a_run_len : assert property (@(posedge clk) disable iff (reset)
    run_valid |-> (run_o.len != '0));

endmodule

`default_nettype wire

/* lcd/spi_byte_tx.sv */
// spi mode 3 byte shifter
`default_nettype none

module spi_byte_tx (
  input  logic       clk,
  input  logic       reset,
  input  logic [7:0] byte_in,
  input  logic       dc_in,
  input  logic       load,
  output logic       done,
  output logic       spi_clk,
  output logic       spi_mosi,
  output logic       spi_dc
);
  logic       active;
  logic [3:0] phase;  // half periods of spi_clk
  logic [7:0] sh;
  logic       dc_q;

  assign spi_mosi = sh[7];  // msb first
  assign spi_dc   = dc_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      active  <= 1'b0;
      phase   <= '0;
      spi_clk <= 1'b1;  // idles high
      done    <= 1'b0;
    end else begin
      done <= 1'b0;
      if (!active) begin
        if (load) begin
          active  <= 1'b1;
          phase   <= '0;
          spi_clk <= 1'b0;  // first falling edge with bit 7
        end
      end else begin
        spi_clk <= ~spi_clk;  // clk/2
        phase   <= phase + 4'd1;
        if (phase == 4'd14) begin  // eighth rising edge
          active <= 1'b0;
          done   <= 1'b1;
        end
      end
    end
  end

  // data moves on the falling edge only
  always_ff @(posedge clk) begin
    if (!active && load) begin
      sh   <= byte_in;
      dc_q <= dc_in;
    end else if (active && spi_clk) begin
      sh <= {sh[6:0], 1'b0};
    end
  end

endmodule

`default_nettype wire

/* lcd/lcd_hvline.sv */
// st7789 run writer
`default_nettype none

module lcd_hvline (
  input  logic              clk,
  input  logic              reset,
  input  draw_pkg::hvline_t run_i,
  input  logic              run_valid,
  output logic              run_ready,
  output logic              lcd_busy,
  output logic              spi_csn,
  output logic              spi_clk,
  output logic              spi_mosi,
  output logic              spi_dc
);
  import draw_pkg::*;

  lcd_state_e       state;
  hvline_t          run_q;
  logic             kick;       // first byte of a run
  logic             final_q;    // byte on the wire is the last one
  logic [3:0]       idx;        // 0..10 header, 11 pixels
  logic             lo;         // next pixel byte is the low one
  logic [coord_w:0] pix_cnt;    // pixels still to start
  logic [15:0]      xs, xe, ys, ye;
  logic [15:0]      span_end_x, span_end_y;
  logic [7:0]       tx_byte;
  logic             tx_dc;
  logic             load, done;

  assign run_ready = (state == lcd_idle);
  assign lcd_busy  = (state != lcd_idle);
  assign load      = (state == lcd_send) && !final_q && (kick || done);

  // address window, end = start + len - 1 on the run axis
  assign span_end_x = {1'b0, run_q.x} + run_q.len - 16'd1;
  assign span_end_y = {1'b0, run_q.y} + run_q.len - 16'd1;
  assign xs = {1'b0, run_q.x};
  assign ys = {1'b0, run_q.y};
  assign xe = run_q.vertical ? xs : span_end_x;
  assign ye = run_q.vertical ? span_end_y : ys;

  always_comb begin
    tx_dc = 1'b1;
    case (idx)
      4'd0:    begin tx_byte = op_caset; tx_dc = 1'b0; end
      4'd1:    tx_byte = xs[15:8];
      4'd2:    tx_byte = xs[7:0];
      4'd3:    tx_byte = xe[15:8];
      4'd4:    tx_byte = xe[7:0];
      4'd5:    begin tx_byte = op_raset; tx_dc = 1'b0; end
      4'd6:    tx_byte = ys[15:8];
      4'd7:    tx_byte = ys[7:0];
      4'd8:    tx_byte = ye[15:8];
      4'd9:    tx_byte = ye[7:0];
      4'd10:   begin tx_byte = op_ramwr; tx_dc = 1'b0; end
      default: tx_byte = lo ? run_q.color[7:0] : run_q.color[15:8];  // pixel, hi first
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= lcd_idle;
      spi_csn <= 1'b1;
      kick    <= 1'b0;
    end else begin
      kick <= 1'b0;
      case (state)
        lcd_idle: if (run_valid) begin
          state   <= lcd_send;
          spi_csn <= 1'b0;
          kick    <= 1'b1;
        end
        lcd_send: if (done && final_q) begin
          state   <= lcd_gap;
          spi_csn <= 1'b1;
        end
        lcd_gap: state <= lcd_idle;  // csn high through gap and idle
        default: state <= lcd_idle;
      endcase
    end
  end

  // byte sequencing
  always_ff @(posedge clk) begin
    if (state == lcd_idle && run_valid) begin
      run_q   <= run_i;
      idx     <= 4'd0;
      final_q <= 1'b0;
    end else if (load) begin
      if (idx != 4'd11) begin
        idx <= idx + 4'd1;
        if (idx == 4'd10) begin
          lo      <= 1'b0;
          pix_cnt <= run_q.len;
        end
      end else if (!lo) begin
        lo <= 1'b1;
      end else begin
        lo      <= 1'b0;
        pix_cnt <= pix_cnt - 1'b1;
        final_q <= (pix_cnt == 1);
      end
    end
  end

  spi_byte_tx spi_byte_tx_i (
    .clk      (clk),
    .reset    (reset),
    .byte_in  (tx_byte),
    .dc_in    (tx_dc),
    .load     (load),
    .done     (done),
    .spi_clk  (spi_clk),
    .spi_mosi (spi_mosi),
    .spi_dc   (spi_dc)
  );

endmodule

`default_nettype wire

/* hdl/draw_top.sv */
// polyline renderer top
`default_nettype none

module draw_top (
  input  logic        clk,
  input  logic        reset,
  input  logic        cyc,
  input  logic        stb,
  input  logic        we,
  input  logic [9:0]  adr,
  input  logic [31:0] dat_w,
  output logic [31:0] dat_r,
  output logic        ack,
  output logic        spi_csn,
  output logic        spi_clk,
  output logic        spi_mosi,
  output logic        spi_dc
);
  import draw_pkg::*;

  logic        start;
  logic [15:0] color;
  logic [7:0]  rd_addr;
  logic [31:0] rd_data;
  logic        walk_busy, bres_busy, lcd_busy;
  line_req_t   line_w;
  logic        line_valid, line_ready;
  hvline_t     run_w;
  logic        run_valid, run_ready;
  logic        run_fire;

  assign run_fire = run_valid & run_ready;  // counted in status

  draw_regs draw_regs_i (
    .clk(clk), .reset(reset),
    .cyc(cyc), .stb(stb), .we(we), .adr(adr), .dat_w(dat_w), .dat_r(dat_r), .ack(ack),
    .start(start), .color(color), .rd_addr(rd_addr), .rd_data(rd_data),
    .walk_busy(walk_busy), .bres_busy(bres_busy), .lcd_busy(lcd_busy),
    .run_fire(run_fire)
  );

  polyline_walker polyline_walker_i (
    .clk(clk), .reset(reset), .start(start), .color(color),
    .rd_addr(rd_addr), .rd_data(rd_data),
    .line_o(line_w), .line_valid(line_valid), .line_ready(line_ready),
    .walk_busy(walk_busy)
  );

  bresenham_runs bresenham_runs_i (
    .clk(clk), .reset(reset),
    .line_i(line_w), .line_valid(line_valid), .line_ready(line_ready),
    .run_o(run_w), .run_valid(run_valid), .run_ready(run_ready),
    .bres_busy(bres_busy)
  );

  lcd_hvline lcd_hvline_i (
    .clk(clk), .reset(reset),
    .run_i(run_w), .run_valid(run_valid), .run_ready(run_ready), .lcd_busy(lcd_busy),
    .spi_csn(spi_csn), .spi_clk(spi_clk), .spi_mosi(spi_mosi), .spi_dc(spi_dc)
  );

endmodule

`default_nettype wire

/* tests/spi_lcd_monitor.sv */
// spi display model
`default_nettype none

module spi_lcd_monitor (
  input  logic              spi_csn,
  input  logic              spi_clk,
  input  logic              spi_mosi,
  input  logic              spi_dc,
  output draw_pkg::hvline_t run,          // most recent run
  output int                run_count,    // runs decoded so far
  output int                window_errs   // window size disagrees with pixels
);
  timeunit 1ns;
  timeprecision 1ps;
  import draw_pkg::*;

  logic [7:0]  sh;
  logic [7:0]  cmd;       // last command byte
  logic [15:0] win [4];   // xs xe ys ye
  logic [15:0] pix;
  logic [15:0] pix0;      // color of first pixel
  int          nbits;
  int          nwin;
  int          nbytes;
  int          npix;      // pixel bytes after ramwr
  int          wi;
  bit          pix_bad;

  initial begin
    run         = '0;
    run_count   = 0;
    window_errs = 0;
    nbytes      = 0;
  end

  // fresh frame on csn fall
  always @(negedge spi_csn) begin
    nbits   = 0;
    nbytes  = 0;
    npix    = 0;
    nwin    = 0;
    cmd     = 8'h00;
    pix_bad = 1'b0;
  end

  // display samples on the rising edge, msb first
  always @(posedge spi_clk) begin
    if (!spi_csn) begin
      sh    = {sh[6:0], spi_mosi};
      nbits = nbits + 1;
      if (nbits == 8) begin
        nbits  = 0;
        nbytes = nbytes + 1;
        if (!spi_dc) begin
          cmd  = sh;  // command byte
          nwin = 0;
        end else if (cmd == op_caset || cmd == op_raset) begin
          wi      = (cmd == op_raset) ? 2 + nwin / 2 : nwin / 2;
          win[wi] = {win[wi][7:0], sh};  // big endian words
          nwin    = nwin + 1;
        end else if (cmd == op_ramwr) begin
          pix  = {pix[7:0], sh};
          npix = npix + 1;
          if (npix == 2)
            pix0 = pix;
          else if (npix % 2 == 0 && pix != pix0)
            pix_bad = 1'b1;  // runs are one color
        end
      end
    end
  end

  // run complete when csn rises
  always @(posedge spi_csn) begin
    int w;
    int h;
    if (nbytes > 0) begin
      w = int'(win[1]) - int'(win[0]) + 1;
      h = int'(win[3]) - int'(win[2]) + 1;
      if ((w != 1 && h != 1) || w * h != npix / 2 || npix % 2 != 0 || pix_bad || nbits != 0)
        window_errs = window_errs + 1;
      run.x        = win[0][coord_w-1:0];
      run.y        = win[2][coord_w-1:0];
      run.len      = (coord_w+1)'(npix / 2);
      run.vertical = (h > 1);  // unknowable for one pixel
      run.color    = pix0;
      run_count    = run_count + 1;
      nbytes       = 0;
    end
  end

endmodule

`default_nettype wire

/* tests/tb_draw_top.sv */
// polyline renderer testbench
`default_nettype none

module tb_draw_top;
  timeunit 1ns;
  timeprecision 1ps;
  import draw_pkg::*;

  typedef logic [31:0] word_q_t [$];
  typedef hvline_t     run_q_t [$];

  logic        clk;
  logic        reset;
  logic        cyc;
  logic        stb;
  logic        we;
  logic        ack;
  logic [9:0]  adr;
  logic [31:0] dat_w;
  logic [31:0] dat_r;
  logic        spi_csn;
  logic        spi_clk;
  logic        spi_mosi;
  logic        spi_dc;
  hvline_t     mon_run;
  int          mon_count;
  int          mon_window_errs;
  run_q_t      exp_q;                 // runs still awaited
  int          exp_total;             // runs of the current drawing
  int          runs_seen = 0;
  int          window_errs_seen = 0;
  int          errors = 0;
  int          checks = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;
  int          seed = 43155;
  time         deadline = 0;          // 0 while unarmed

  draw_top dut_i (
    .clk(clk), .reset(reset),
    .cyc(cyc), .stb(stb), .we(we), .adr(adr), .dat_w(dat_w), .dat_r(dat_r), .ack(ack),
    .spi_csn(spi_csn), .spi_clk(spi_clk), .spi_mosi(spi_mosi), .spi_dc(spi_dc)
  );

  spi_lcd_monitor monitor_i (
    .spi_csn(spi_csn), .spi_clk(spi_clk), .spi_mosi(spi_mosi), .spi_dc(spi_dc),
    .run(mon_run), .run_count(mon_count), .window_errs(mon_window_errs)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // 100 ns period
  end

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] want);
    checks++;
    assert (got === want) else begin
      $display("** Error at %0d ns: %s is %0h, expected %0h", $time, name, got, want);
      errors++;
    end
  endtask

  task automatic check_true(input bit ok, input string what);
    checks++;
    assert (ok) else begin
      $display("Error at %0d ns: %s", $time, what);
      errors++;
    end
  endtask

  // one wishbone classic cycle, inputs change on the falling edge
  task automatic bus_access(input logic write, input logic [9:0] a, input logic [31:0] d,
                            output logic [31:0] q);
    int n;
    @(negedge clk);
    cyc   = 1'b1;
    stb   = 1'b1;
    we    = write;
    adr   = a;
    dat_w = d;
    n     = 0;
    @(negedge clk);
    while (!ack && n < 8) begin
      @(negedge clk);
      n++;
    end
    check_true(ack == 1'b1, "Wishbone cycle got no ack");
    q   = dat_r;  // registered with ack
    cyc = 1'b0;
    stb = 1'b0;
    we  = 1'b0;
  endtask

  task automatic write_word(input logic [9:0] a, input logic [31:0] d);
    logic [31:0] unused;
    bus_access(1'b1, a, d, unused);
  endtask

  function automatic logic [31:0] point_word(input int x, input int y, input bit disc,
                                             input bit last);
    return {last, y[14:0], disc, x[14:0]};
  endfunction

  // expected runs, pairing rule on the points then bresenham per segment
  function automatic run_q_t ref_runs(input word_q_t pts, input logic [15:0] color);
    run_q_t  runs;
    hvline_t r;
    int      x0, y0, x1, y1, x, y;
    int      dx, dy, sx, sy, err, e2;
    bit      have_pen;
    bit      xmaj;
    have_pen = 1'b0;
    x0 = 0;
    y0 = 0;
    for (int i = 0; i < pts.size() && i < point_depth; i++) begin
      x1 = int'(pts[i][14:0]);
      y1 = int'(pts[i][30:16]);
      if (have_pen && !pts[i][15]) begin
        dx    = (x1 > x0) ? x1 - x0 : x0 - x1;
        dy    = (y1 > y0) ? y1 - y0 : y0 - y1;
        sx    = (x1 >= x0) ? 1 : -1;
        sy    = (y1 >= y0) ? 1 : -1;
        err   = dx - dy;
        xmaj  = (dx >= dy);
        x     = x0;
        y     = y0;
        r.len = '0;
        forever begin
          if (r.len != 0 && (xmaj ? y == int'(r.y) : x == int'(r.x))) begin
            r.len = r.len + 1'b1;  // same minor coordinate
            if (x < int'(r.x)) r.x = coord_t'(x);
            if (y < int'(r.y)) r.y = coord_t'(y);
          end else begin
            if (r.len != 0) runs.push_back(r);
            r.x        = coord_t'(x);
            r.y        = coord_t'(y);
            r.len      = 16'd1;
            r.vertical = !xmaj;
            r.color    = color;
          end
          if (x == x1 && y == y1) break;
          e2 = 2 * err;
          if (e2 > -dy) begin
            err = err - dy;
            x   = x + sx;
          end
          if (e2 < dx) begin
            err = err + dx;
            y   = y + sy;
          end
        end
        runs.push_back(r);
      end
      x0       = x1;  // every point becomes the pen
      y0       = y1;
      have_pen = 1'b1;
      if (pts[i][31]) break;
    end
    return runs;
  endfunction

  task automatic arm_watchdog(input int cycles);
    deadline = $time + 100 * cycles;
  endtask

  task automatic load_drawing(input word_q_t pts, input logic [15:0] color);
    run_q_t exp;
    int     budget;
    exp    = ref_runs(pts, color);
    budget = 200 * pts.size() + 400;  // bus traffic and status polls
    foreach (exp[i]) begin
      budget += 2 * (9 + 2 * int'(exp[i].len)) * 16;
      exp_q.push_back(exp[i]);
    end
    arm_watchdog(budget);
    exp_total = exp.size();
    foreach (pts[i]) write_word(point_base[11:2] + 10'(i), pts[i]);
    write_word(reg_color[11:2], {16'h0000, color});
  endtask

  task automatic finish_drawing();
    logic [31:0] q;
    q = 32'h1;
    while (q[0]) bus_access(1'b0, reg_status[11:2], 32'h0, q);  // wait for idle
    check_eq("status.run_count", 32'(q[15:8]), exp_total % 256);
    check_eq("runs never received", exp_q.size(), 0);
    check_eq("window errors", mon_window_errs - window_errs_seen, 0);
    window_errs_seen = mon_window_errs;
    exp_q.delete();
  endtask

  task automatic draw(input word_q_t pts, input logic [15:0] color);
    load_drawing(pts, color);
    write_word(reg_ctrl[11:2], 32'h1);
    finish_drawing();
  endtask

  task automatic draw_segment(input int x0, input int y0, input int x1, input int y1,
                              input logic [15:0] color);
    word_q_t pts;
    pts.push_back(point_word(x0, y0, 1'b0, 1'b0));
    pts.push_back(point_word(x1, y1, 1'b0, 1'b1));
    draw(pts, color);
  endtask

  task automatic end_test(input string name, input int errors_before);
    if (errors == errors_before) begin
      tests_passed++;
      $display("test %s passed", name);
    end else begin
      tests_failed++;
      $display("test %s failed with %0d errors", name, errors - errors_before);
    end
  endtask

  // run checker
  initial begin
    hvline_t e;
    forever begin
      wait (mon_count > runs_seen);
      runs_seen++;
      check_true(exp_q.size() > 0, "the display received a run that was not expected");
      if (exp_q.size() > 0) begin
        e = exp_q.pop_front();
        check_eq("run.x", 32'(mon_run.x), 32'(e.x));
        check_eq("run.y", 32'(mon_run.y), 32'(e.y));
        check_eq("run.len", 32'(mon_run.len), 32'(e.len));
        check_eq("run.color", 32'(mon_run.color), 32'(e.color));
        if (e.len > 1)
          check_eq("run.vertical", 32'(mon_run.vertical), 32'(e.vertical));
      end
    end
  end

  // watchdog
  initial begin
    while (deadline == 0 || $time <= deadline) @(posedge clk);
    $display("Error at %0d ns: watchdog expired before the drawing finished", $time);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    word_q_t     pts;
    logic [31:0] q;
    logic [31:0] words [16];
    int          e0, n0, n, x, y;
    bit          disc;
    reset = 1'b1;
    cyc   = 1'b0;
    stb   = 1'b0;
    we    = 1'b0;
    adr   = '0;
    dat_w = '0;
    arm_watchdog(100);
    repeat (10) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    e0 = errors;
    arm_watchdog(400);
    bus_access(1'b0, reg_status[11:2], 32'h0, q);
    check_eq("status", q, 32'h0);
    check_eq("spi_csn", 32'(spi_csn), 32'h1);
    write_word(reg_color[11:2], 32'h0000F81F);
    bus_access(1'b0, reg_color[11:2], 32'h0, q);
    check_eq("color", q, 32'h0000F81F);
    for (int i = 0; i < 16; i++) begin
      words[i] = $random(seed);
      write_word(point_base[11:2] + 10'(i * 17), words[i]);  // spread over the ram
    end
    for (int i = 0; i < 16; i++) begin
      bus_access(1'b0, point_base[11:2] + 10'(i * 17), 32'h0, q);
      check_eq($sformatf("point[%0d]", i * 17), q, words[i]);
    end
    end_test("register access", e0);

    e0 = errors;
    n0 = mon_count;
    draw_segment(12, 30, 47, 30, 16'h07E0);
    check_eq("runs of horizontal segment", mon_count - n0, 1);
    n0 = mon_count;
    draw_segment(90, 15, 90, 44, 16'h001F);
    check_eq("runs of vertical segment", mon_count - n0, 1);
    end_test("single segment", e0);

    e0 = errors;
    draw_segment(10, 20, 40, 29, 16'hF800);   // shallow
    draw_segment(50, 10, 57, 60, 16'h1234);   // steep
    draw_segment(100, 80, 60, 70, 16'hABCD);  // both axes decreasing
    draw_segment(30, 90, 25, 40, 16'h0F0F);   // steep, x decreasing
    end_test("sloped segments", e0);

    e0 = errors;
    pts.delete();
    pts.push_back(point_word(20, 20, 1'b0, 1'b0));
    pts.push_back(point_word(60, 30, 1'b0, 1'b0));
    pts.push_back(point_word(60, 70, 1'b1, 1'b0));   // pen up
    pts.push_back(point_word(30, 90, 1'b0, 1'b0));
    pts.push_back(point_word(80, 100, 1'b0, 1'b1));  // end of list
    pts.push_back(point_word(5, 5, 1'b0, 1'b0));     // never drawn
    pts.push_back(point_word(200, 200, 1'b0, 1'b1));
    draw(pts, 16'h7BEF);
    end_test("polyline flags", e0);

    e0 = errors;
    pts.delete();
    pts.push_back(point_word(5, 200, 1'b0, 1'b0));
    pts.push_back(point_word(150, 120, 1'b0, 1'b1));
    n0 = mon_count;
    load_drawing(pts, 16'hFFE0);
    write_word(reg_ctrl[11:2], 32'h1);
    repeat (20) @(negedge clk);  // walker idle again, runs still on the wire
    bus_access(1'b0, reg_status[11:2], 32'h0, q);
    check_eq("status.busy", 32'(q[0]), 32'h1);
    write_word(reg_ctrl[11:2], 32'h1);  // dropped, still busy
    finish_drawing();
    repeat (20) @(negedge clk);
    bus_access(1'b0, reg_status[11:2], 32'h0, q);
    check_eq("status.busy", 32'(q[0]), 32'h0);
    check_eq("runs of one drawing", mon_count - n0, exp_total);
    end_test("busy and start", e0);

    e0 = errors;
    for (int t = 0; t < 20; t++) begin
      pts.delete();
      n = 2 + int'($unsigned($random(seed)) % 5);
      for (int i = 0; i < n; i++) begin
        x    = $unsigned($random(seed)) % 240;
        y    = $unsigned($random(seed)) % 240;
        disc = (i > 0) && ($unsigned($random(seed)) % 5 == 0);
        pts.push_back(point_word(x, y, disc, i == n - 1));
      end
      draw(pts, 16'($random(seed)));
    end
    end_test("random polylines", e0);

    $display("tests passed %0d, failed %0d, checks %0d, errors %0d",
             tests_passed, tests_failed, checks, errors);
    if (errors == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
common/draw_pkg.sv
hdl/draw_regs.sv
hdl/polyline_walker.sv
line/bresenham_runs.sv
lcd/spi_byte_tx.sv
lcd/lcd_hvline.sv
hdl/draw_top.sv
tests/spi_lcd_monitor.sv
tests/tb_draw_top.sv
